// ==== uart_pkg.sv ====
// shared UART types; frames are fixed 8N1, and a bit time may not exceed 65535 clocks
`default_nettype none

package uart_pkg;

	// ----------------------------------------
	// data path types
	// ----------------------------------------

	// one byte on the host and FIFO side
	typedef logic [7:0] byte_t;

	// data bits per frame, sent LSB first
	localparam int DATA_BITS = 8;

	// index of the current data bit, 0 to DATA_BITS-1
	typedef logic [2:0] bit_cnt_t;

	// clocks elapsed inside one bit time
	typedef logic [15:0] baud_cnt_t;

	// ----------------------------------------
	// status and control
	// ----------------------------------------

	// one FIFO's level flags, all registered
	// half_full is set at occupancy >= depth/2
	typedef struct packed {
		logic empty;
		logic half_full;
		logic full;
	} fifo_status_t;

	// frame walk, shared by serializer and deserializer
	// IDLE   line high, waiting
	// START  start bit (low)
	// DATA   eight data bits
	// STOP   stop bit (high)
	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} uart_state_t;

endpackage

`default_nettype wire

// ==== uart_fifo.sv ====
// show-ahead FIFO; FIFO_DEPTH must be a power of two of at least 4, and blocked accesses are lost
`timescale 1ns/1ps
`default_nettype none

module uart_fifo import uart_pkg::*; #(
	parameter int unsigned FIFO_DEPTH = 16
) (
	input  wire          clk,
	input  wire          i_rst,
	input  wire          i_wr,
	input  wire byte_t   i_din,
	input  wire          i_rd,
	output byte_t        o_dout,
	output fifo_status_t o_status
);

	// ----------------------------------------
	// sizing
	// ----------------------------------------

	// address bits, pointers carry one extra wrap bit
	localparam int unsigned AW = $clog2(FIFO_DEPTH);

	// pointer and occupancy width, holds 0..FIFO_DEPTH
	typedef logic [AW:0] ptr_t;

	byte_t mem [FIFO_DEPTH];

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	ptr_t count;
	ptr_t count_next;
	logic wr_en;
	logic rd_en;

	// ----------------------------------------
	// access qualification
	// ----------------------------------------

	// write while full and read while empty are dropped here
	assign wr_en = i_wr && !o_status.full;
	assign rd_en = i_rd && !o_status.empty;

	// occupancy after this edge, constant on rd+wr
	assign count_next = count + ptr_t'(wr_en) - ptr_t'(rd_en);

	// ----------------------------------------
	// storage
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr[AW-1:0]] <= i_din;
		end
	end

	// head word always on the output
	assign o_dout = mem[rd_ptr[AW-1:0]];

	// ----------------------------------------
	// pointers, count and flags
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (i_rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			o_status <= '{empty: 1'b1, half_full: 1'b0, full: 1'b0};
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + ptr_t'(1);
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + ptr_t'(1);
			end
			count <= count_next;
			// flags follow the new occupancy on the same edge
			o_status.empty     <= (count_next == '0);
			o_status.half_full <= (count_next >= ptr_t'(FIFO_DEPTH / 2));
			o_status.full      <= (count_next == ptr_t'(FIFO_DEPTH));
		end
	end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
// 8N1 serializer; clock/baud must give 2 to 65535 clocks per bit, remainder of the ratio is dropped
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; #(
	parameter int unsigned UART_CLK_FREQ_KHZ = 50000,
	parameter int unsigned UART_BAUD_RATE    = 115200
) (
	input  wire               clk,
	input  wire               i_rst,
	input  wire byte_t        i_fifo_data,
	input  wire fifo_status_t i_fifo_status,
	output logic              o_fifo_rd,
	output logic              o_uart_tx_ser
);

	// ----------------------------------------
	// bit timing
	// ----------------------------------------

	localparam int unsigned CLKS_PER_BIT = (UART_CLK_FREQ_KHZ * 1000) / UART_BAUD_RATE;
	localparam baud_cnt_t   BIT_LAST     = baud_cnt_t'(CLKS_PER_BIT - 1);
	localparam bit_cnt_t    DATA_LAST    = bit_cnt_t'(DATA_BITS - 1);

	uart_state_t state;
	baud_cnt_t   baud_cnt;
	bit_cnt_t    bit_cnt;
	byte_t       shift;
	logic        bit_done;
	logic        pop;

	assign bit_done = (baud_cnt == BIT_LAST);

	// pop head byte as soon as idle and data waits
	assign pop       = (state == IDLE) && !i_fifo_status.empty;
	assign o_fifo_rd = pop;

	// ----------------------------------------
	// data shift register
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (pop) begin
			shift <= i_fifo_data;
		end else if (state == DATA && bit_done) begin
			shift <= shift >> 1;
		end
	end

	// ----------------------------------------
	// frame FSM, line output registered
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state         <= IDLE;
			baud_cnt      <= '0;
			bit_cnt       <= '0;
			o_uart_tx_ser <= 1'b1;
		end else begin
			// counter restarts at every bit boundary
			if (state == IDLE || bit_done) begin
				baud_cnt <= '0;
			end else begin
				baud_cnt <= baud_cnt + baud_cnt_t'(1);
			end
			case (state)
				IDLE: begin
					o_uart_tx_ser <= 1'b1;
					if (pop) begin
						state         <= START;
						o_uart_tx_ser <= 1'b0;
					end
				end
				START: begin
					if (bit_done) begin
						state         <= DATA;
						bit_cnt       <= '0;
						o_uart_tx_ser <= shift[0];
					end
				end
				DATA: begin
					if (bit_done) begin
						if (bit_cnt == DATA_LAST) begin
							state         <= STOP;
							o_uart_tx_ser <= 1'b1;
						end else begin
							bit_cnt       <= bit_cnt + bit_cnt_t'(1);
							// next bit, before the shift lands
							o_uart_tx_ser <= shift[1];
						end
					end
				end
				STOP: begin
					if (bit_done) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
// 8N1 deserializer; needs 2 to 65535 clocks per bit, bad frames and frames hitting a full FIFO vanish
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; #(
	parameter int unsigned UART_CLK_FREQ_KHZ = 50000,
	parameter int unsigned UART_BAUD_RATE    = 115200
) (
	input  wire               clk,
	input  wire               i_rst,
	input  wire               i_uart_rx_ser,
	input  wire fifo_status_t i_fifo_status,
	output logic              o_fifo_wr,
	output byte_t             o_fifo_data
);

	// ----------------------------------------
	// bit timing
	// ----------------------------------------

	localparam int unsigned CLKS_PER_BIT = (UART_CLK_FREQ_KHZ * 1000) / UART_BAUD_RATE;
	localparam baud_cnt_t   BIT_LAST     = baud_cnt_t'(CLKS_PER_BIT - 1);
	// start bit is re-checked at its middle
	localparam baud_cnt_t   HALF_LAST    = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);
	localparam bit_cnt_t    DATA_LAST    = bit_cnt_t'(DATA_BITS - 1);

	uart_state_t state;
	baud_cnt_t   baud_cnt;
	bit_cnt_t    bit_cnt;
	byte_t       shift;
	logic        rx_meta;
	logic        rx_sync;
	logic        rx_prev;
	logic        fall;
	logic        bit_done;
	logic        half_done;
	logic        cnt_clr;

	// ----------------------------------------
	// input synchronizer and edge detect
	// ----------------------------------------

	// two flops, then one more for the edge
	always_ff @(posedge clk) begin
		if (i_rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= i_uart_rx_ser;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign fall = rx_prev && !rx_sync;

	assign bit_done  = (baud_cnt == BIT_LAST);
	assign half_done = (baud_cnt == HALF_LAST);

	// start state runs on the half bit, the rest on full bits
	assign cnt_clr = (state == IDLE) || ((state == START) ? half_done : bit_done);

	// ----------------------------------------
	// data capture at bit centers
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (state == DATA && bit_done) begin
			shift <= {rx_sync, shift[7:1]};
		end
	end

	assign o_fifo_data = shift;

	// ----------------------------------------
	// frame FSM
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state     <= IDLE;
			baud_cnt  <= '0;
			bit_cnt   <= '0;
			o_fifo_wr <= 1'b0;
		end else begin
			o_fifo_wr <= 1'b0;
			if (cnt_clr) begin
				baud_cnt <= '0;
			end else begin
				baud_cnt <= baud_cnt + baud_cnt_t'(1);
			end
			case (state)
				IDLE: begin
					if (fall) begin
						state <= START;
					end
				end
				START: begin
					// line high again at mid start means a glitch
					if (half_done) begin
						state   <= rx_sync ? IDLE : DATA;
						bit_cnt <= '0;
					end
				end
				DATA: begin
					if (bit_done) begin
						if (bit_cnt == DATA_LAST) begin
							state <= STOP;
						end else begin
							bit_cnt <= bit_cnt + bit_cnt_t'(1);
						end
					end
				end
				STOP: begin
					if (bit_done) begin
						state <= IDLE;
						// good stop bit and room left, else drop
						o_fifo_wr <= rx_sync && !i_fifo_status.full;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== uart_tx_rx.sv ====
// UART transceiver top; fixed 8N1, no parity, no flow control, no error outputs, baud set at build
`timescale 1ns/1ps
`default_nettype none

module uart_tx_rx import uart_pkg::*; #(
	parameter int unsigned UART_CLK_FREQ_KHZ = 50000,
	parameter int unsigned UART_BAUD_RATE    = 115200,
	parameter int unsigned FIFO_DEPTH        = 16
) (
	input  wire        clk,
	input  wire        i_rst,
	// host transmit side
	input  wire        i_tx_fifo_wr,
	input  wire byte_t i_tx_fifo_din,
	output logic       o_tx_fifo_full,
	output logic       o_tx_fifo_half_full,
	// serial lines
	output logic       o_uart_tx_ser,
	input  wire        i_uart_rx_ser,
	// host receive side
	input  wire        i_rx_fifo_rd,
	output logic       o_rx_fifo_empty,
	output logic       o_rx_fifo_full,
	output logic       o_rx_fifo_half_full,
	output byte_t      o_rx_fifo_dout
);

	// ----------------------------------------
	// transmit path
	// ----------------------------------------

	fifo_status_t tx_status;
	byte_t        tx_fifo_data;
	logic         tx_fifo_rd;

	uart_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) tx_fifo_inst (
		.clk      (clk),
		.i_rst    (i_rst),
		.i_wr     (i_tx_fifo_wr),
		.i_din    (i_tx_fifo_din),
		.i_rd     (tx_fifo_rd),
		.o_dout   (tx_fifo_data),
		.o_status (tx_status)
	);

	uart_tx #(
		.UART_CLK_FREQ_KHZ (UART_CLK_FREQ_KHZ),
		.UART_BAUD_RATE    (UART_BAUD_RATE)
	) uart_tx_inst (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_fifo_data   (tx_fifo_data),
		.i_fifo_status (tx_status),
		.o_fifo_rd     (tx_fifo_rd),
		.o_uart_tx_ser (o_uart_tx_ser)
	);

	// ----------------------------------------
	// receive path
	// ----------------------------------------

	fifo_status_t rx_status;
	byte_t        rx_fifo_data;
	logic         rx_fifo_wr;

	uart_rx #(
		.UART_CLK_FREQ_KHZ (UART_CLK_FREQ_KHZ),
		.UART_BAUD_RATE    (UART_BAUD_RATE)
	) uart_rx_inst (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_uart_rx_ser (i_uart_rx_ser),
		.i_fifo_status (rx_status),
		.o_fifo_wr     (rx_fifo_wr),
		.o_fifo_data   (rx_fifo_data)
	);

	uart_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) rx_fifo_inst (
		.clk      (clk),
		.i_rst    (i_rst),
		.i_wr     (rx_fifo_wr),
		.i_din    (rx_fifo_data),
		.i_rd     (i_rx_fifo_rd),
		.o_dout   (o_rx_fifo_dout),
		.o_status (rx_status)
	);

	// status fields out to the host flag pins
	assign o_tx_fifo_full      = tx_status.full;
	assign o_tx_fifo_half_full = tx_status.half_full;
	assign o_rx_fifo_empty     = rx_status.empty;
	assign o_rx_fifo_full      = rx_status.full;
	assign o_rx_fifo_half_full = rx_status.half_full;

endmodule

`default_nettype wire

// ==== tb_uart_tx_rx.sv ====
// directed testbench for uart_tx_rx; 8 clocks per bit and FIFO depth 8 are assumed in test sizes
`timescale 1ns/1ps
`default_nettype none

module tb_uart_tx_rx import uart_pkg::*; ();

	// ----------------------------------------
	// setup
	// ----------------------------------------

	localparam int CLK_KHZ      = 250000;
	localparam int BAUD         = 31250000;
	localparam int DEPTH        = 8;
	localparam int CLKS_PER_BIT = CLK_KHZ * 1000 / BAUD;
	// flag waits give up after 50 bit times
	localparam int TIMEOUT      = 50 * CLKS_PER_BIT;
	localparam int IDLE_RUN     = 12 * CLKS_PER_BIT;
	localparam int IDLE_LIMIT   = 200 * CLKS_PER_BIT;
	localparam int BURST_LEN    = 20;

	logic  clk;
	logic  rst;
	logic  tx_wr;
	byte_t tx_din;
	logic  rx_rd;
	logic  tx_full;
	logic  tx_half;
	logic  tx_ser;
	logic  rx_empty;
	logic  rx_full;
	logic  rx_half;
	byte_t rx_dout;
	// loopback picks the DUT's own tx line, else the bit driver
	logic  loopback;
	logic  ser_drv;
	logic  rx_line;

	int errors;
	int timeouts;

	assign rx_line = loopback ? tx_ser : ser_drv;

	uart_tx_rx #(
		.UART_CLK_FREQ_KHZ (CLK_KHZ),
		.UART_BAUD_RATE    (BAUD),
		.FIFO_DEPTH        (DEPTH)
	) UUT (
		.clk                 (clk),
		.i_rst               (rst),
		.i_tx_fifo_wr        (tx_wr),
		.i_tx_fifo_din       (tx_din),
		.o_tx_fifo_full      (tx_full),
		.o_tx_fifo_half_full (tx_half),
		.o_uart_tx_ser       (tx_ser),
		.i_uart_rx_ser       (rx_line),
		.i_rx_fifo_rd        (rx_rd),
		.o_rx_fifo_empty     (rx_empty),
		.o_rx_fifo_full      (rx_full),
		.o_rx_fifo_half_full (rx_half),
		.o_rx_fifo_dout      (rx_dout)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s, got %02h expected %02h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s, got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// ----------------------------------------
	// waits and host access
	// ----------------------------------------

	// returns on a falling edge with room in the tx FIFO
	task automatic wait_tx_room();
		int n;
		n = 0;
		@(negedge clk);
		while (tx_full && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (tx_full) begin
			$display("timeout: o_tx_fifo_full never dropped at %0t", $time);
			timeouts++;
		end
	endtask

	task automatic wait_rx_data(input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (rx_empty && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (rx_empty) begin
			$display("timeout: o_rx_fifo_empty never fell for %s at %0t", what, $time);
			timeouts++;
		end
	endtask

	// line must stay high for 12 bit times in a row
	task automatic wait_line_idle();
		int run;
		int n;
		run = 0;
		n = 0;
		while (run < IDLE_RUN && n < IDLE_LIMIT) begin
			@(negedge clk);
			run = rx_line ? run + 1 : 0;
			n++;
		end
		if (run < IDLE_RUN) begin
			$display("timeout: serial line never idle for 12 bit times at %0t", $time);
			timeouts++;
		end
	endtask

	task automatic write_byte(input byte_t b);
		wait_tx_room();
		tx_wr  = 1'b1;
		tx_din = b;
		@(negedge clk);
		tx_wr  = 1'b0;
	endtask

	// head byte is valid while not empty and one read pulse pops it
	task automatic read_rx(output byte_t got, input string what);
		wait_rx_data(what);
		got   = rx_dout;
		rx_rd = 1'b1;
		@(negedge clk);
		rx_rd = 1'b0;
	endtask

	// ----------------------------------------
	// serial line driver
	// ----------------------------------------

	task automatic drive_bit(input logic v, input int cycles);
		ser_drv = v;
		repeat (cycles) @(negedge clk);
	endtask

	// start, eight data bits LSB first, then the given stop level
	task automatic send_frame(input byte_t b, input logic stop_bit);
		byte_t data;
		data = b;
		drive_bit(1'b0, CLKS_PER_BIT);
		for (int i = 0; i < DATA_BITS; i++) begin
			drive_bit(data[0], CLKS_PER_BIT);
			data = data >> 1;
		end
		drive_bit(stop_bit, CLKS_PER_BIT);
		ser_drv = 1'b1;
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------

	task automatic test_reset_state();
		check_flag(tx_ser, 1'b1, "tx line after reset");
		check_flag(rx_empty, 1'b1, "rx empty after reset");
		check_flag(tx_full, 1'b0, "tx full after reset");
		check_flag(tx_half, 1'b0, "tx half-full after reset");
		check_flag(rx_full, 1'b0, "rx full after reset");
		check_flag(rx_half, 1'b0, "rx half-full after reset");
	endtask

	task automatic test_single_byte();
		byte_t got;
		write_byte(8'ha5);
		read_rx(got, "single byte");
		check_byte(got, 8'ha5, "single byte");
		check_flag(rx_empty, 1'b1, "rx empty after single read");
	endtask

	// writer and reader run side by side
	task automatic test_burst();
		byte_t sent[$];
		byte_t b;
		byte_t got;
		fork
			begin
				for (int i = 0; i < BURST_LEN; i++) begin
					b = byte_t'($urandom());
					sent.push_back(b);
					write_byte(b);
				end
			end
			begin
				for (int i = 0; i < BURST_LEN; i++) begin
					read_rx(got, "burst byte");
					check_byte(got, sent.pop_front(), "burst byte");
				end
			end
		join
	endtask

	// later frames hit a full rx FIFO and are dropped
	task automatic test_overflow();
		byte_t sent[$];
		byte_t b;
		byte_t got;
		for (int i = 0; i < DEPTH + 3; i++) begin
			b = byte_t'($urandom());
			sent.push_back(b);
			write_byte(b);
		end
		// host writes outrun the serializer, so the tx FIFO is topped up again
		check_flag(tx_full, 1'b1, "tx full after overflow writes");
		check_flag(tx_half, 1'b1, "tx half-full after overflow writes");
		wait_line_idle();
		check_flag(rx_full, 1'b1, "rx full after overflow");
		check_flag(rx_half, 1'b1, "rx half-full after overflow");
		for (int i = 0; i < DEPTH; i++) begin
			read_rx(got, "overflow byte");
			check_byte(got, sent[i], "overflow byte");
		end
		check_flag(rx_empty, 1'b1, "rx empty after overflow drain");
	endtask

	task automatic test_manual_line();
		byte_t b;
		byte_t got;
		b = byte_t'($urandom());
		loopback = 1'b0;
		@(negedge clk);
		// low stop bit
		send_frame(b ^ 8'h5a, 1'b0);
		wait_line_idle();
		check_flag(rx_empty, 1'b1, "rx empty after bad stop bit");
		// low pulse well under half a bit
		drive_bit(1'b0, CLKS_PER_BIT / 2 - 2);
		ser_drv = 1'b1;
		wait_line_idle();
		check_flag(rx_empty, 1'b1, "rx empty after short pulse");
		send_frame(b, 1'b1);
		read_rx(got, "driven frame");
		check_byte(got, b, "driven frame");
		loopback = 1'b1;
	endtask

	task automatic test_half_full();
		byte_t sent[$];
		byte_t b;
		byte_t got;
		for (int i = 0; i < DEPTH / 2; i++) begin
			b = byte_t'($urandom());
			sent.push_back(b);
			write_byte(b);
			wait_line_idle();
			if (i == DEPTH / 2 - 2) begin
				check_flag(rx_half, 1'b0, "rx half-full one below half");
			end
		end
		check_flag(rx_half, 1'b1, "rx half-full at half");
		for (int i = 0; i < DEPTH / 2; i++) begin
			read_rx(got, "half-full byte");
			check_byte(got, sent[i], "half-full byte");
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		errors   = 0;
		timeouts = 0;
		rst      = 1'b1;
		tx_wr    = 1'b0;
		tx_din   = '0;
		rx_rd    = 1'b0;
		loopback = 1'b1;
		ser_drv  = 1'b1;
		void'($urandom(34));
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		test_reset_state();
		test_single_byte();
		test_burst();
		test_overflow();
		test_manual_line();
		test_half_full();
		$display("check errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_tx_rx.sv
tb_uart_tx_rx.sv

// ==== Makefile ====
TOP := tb_uart_tx_rx

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
